/* common/holo_pkg.sv */
// sized for a 320x180 framebuffer; SCAN_DIV is small for simulation and too fast for a real display
`default_nettype none

package holo_pkg;

  // framebuffer size in pixels
  localparam int HRES = 320;
  localparam int VRES = 180;

  // video timing counter widths
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // rgb565 in, 8-bit channels out
  localparam int PIXEL_W = 16;
  localparam int CHAN_W  = 8;

  // mid gray, shown when no pixel is taken from the stream
  localparam logic [PIXEL_W-1:0] GRAY_PIXEL = 16'h8410;

  // vertex coordinate, signed with 14 fraction bits
  localparam int COORD_W = 16;
  // 3 vertices of 3 coordinates each
  localparam int TABLE_DIM = 3;
  // element [v][c] at bit (v*3 + c)*16, [0][0] in the low word
  localparam logic [TABLE_DIM*TABLE_DIM*COORD_W-1:0] VERTEX_TABLE =
    144'h2000e000e0002000e0002000200020002000;

  // triangle fetch
  localparam int NUM_TRI  = 12;
  localparam int TRI_ID_W = 17;

  // display value, eight hex digits
  localparam int DISP_W     = 32;
  localparam int NUM_DIGITS = 8;
  localparam int DIGIT_W    = $clog2(NUM_DIGITS);

  // clocks per digit in the scanner
  localparam int SCAN_DIV   = 64;
  localparam int SCAN_CNT_W = $clog2(SCAN_DIV);

  // probe code taken from sw[15:10]
  localparam int PROBE_W = 6;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_ISSUE
  } fetch_state_e;

  typedef enum logic [PROBE_W-1:0] {
    PROBE_TRI_ID     = 6'd0,
    PROBE_VERTEX     = 6'd1,
    PROBE_TRI_VALID  = 6'd2,
    PROBE_HCOUNT     = 6'd3,
    PROBE_VCOUNT     = 6'd4,
    PROBE_LAST_PIXEL = 6'd5
  } probe_sel_e;

endpackage

`default_nettype wire

/* seven_seg/seven_seg_scan.sv */
// common anode display, anodes and segments active low; one digit lit at a time for SCAN_DIV clocks
`timescale 1ns/1ps
`default_nettype none

module seven_seg_scan (
  input  wire                              clk_100_passthrough,
  input  wire                              recent_reset,
  input  wire  [holo_pkg::DISP_W-1:0]      val_i,
  output logic [holo_pkg::NUM_DIGITS-1:0]  an_o,
  output logic [6:0]                       cat_o
);

  logic [holo_pkg::SCAN_CNT_W-1:0] div_cnt;
  logic [holo_pkg::DIGIT_W-1:0]    digit;

  logic [3:0] nibble;
  // active high, bit 0 = a .. bit 6 = g
  logic [6:0] seg;

  // divider, then step the digit
  always_ff @(posedge clk_100_passthrough) begin
    if (recent_reset) begin
      div_cnt <= '0;
      digit   <= '0;
    end else if (div_cnt == holo_pkg::SCAN_CNT_W'(holo_pkg::SCAN_DIV - 1)) begin
      div_cnt <= '0;
      // wraps after the last digit
      if (digit == holo_pkg::DIGIT_W'(holo_pkg::NUM_DIGITS - 1)) begin
        digit <= '0;
      end else begin
        digit <= digit + 1'b1;
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // only the current anode low
  assign an_o = ~(holo_pkg::NUM_DIGITS'(1) << digit);

  // nibble for this digit, digit 0 = lowest
  assign nibble = val_i[digit*4 +: 4];

  // hex decode
  always_comb begin
    case (nibble)
      4'h0: seg = 7'h3f;
      4'h1: seg = 7'h06;
      4'h2: seg = 7'h5b;
      4'h3: seg = 7'h4f;
      4'h4: seg = 7'h66;
      4'h5: seg = 7'h6d;
      4'h6: seg = 7'h7d;
      4'h7: seg = 7'h07;
      4'h8: seg = 7'h7f;
      4'h9: seg = 7'h6f;
      4'ha: seg = 7'h77;
      4'hb: seg = 7'h7c;
      4'hc: seg = 7'h39;
      4'hd: seg = 7'h5e;
      4'he: seg = 7'h79;
      default: seg = 7'h71;
    endcase
  end

  assign cat_o = ~seg;

endmodule

`default_nettype wire

/* rtl/debug_ctrl.sv */
// buttons are sampled once before edge detection, so no debounce; steps while not ready are dropped
`timescale 1ns/1ps
`default_nettype none

module debug_ctrl (
  input  wire                            clk_100_passthrough,
  input  wire                            recent_reset,
  input  wire  [3:0]                     btn_i,
  input  wire                            raster_ready_i,
  output logic                           tri_valid_o,
  output logic [holo_pkg::TRI_ID_W-1:0]  tri_id_o,
  output logic                           clear_o
);

  // bit 0 step, bit 1 clear
  logic [1:0] btn_q;
  logic [1:0] btn_prev;
  logic [1:0] btn_edge;

  logic step_edge;
  logic clear_edge;

  holo_pkg::fetch_state_e state;

  // id after the current one, wrapping at NUM_TRI
  logic [holo_pkg::TRI_ID_W-1:0] tri_id_next;

  // sample, keep previous level, then register the rise
  always_ff @(posedge clk_100_passthrough) begin
    if (recent_reset) begin
      btn_q    <= '0;
      btn_prev <= '0;
      btn_edge <= '0;
    end else begin
      btn_q    <= btn_i[2:1];
      btn_prev <= btn_q;
      btn_edge <= btn_q & ~btn_prev;
    end
  end

  assign step_edge  = btn_edge[0];
  assign clear_edge = btn_edge[1];

  always_comb begin
    if (tri_id_o == holo_pkg::TRI_ID_W'(holo_pkg::NUM_TRI - 1)) begin
      tri_id_next = '0;
    end else begin
      tri_id_next = tri_id_o + 1'b1;
    end
  end

  // fetch FSM
  always_ff @(posedge clk_100_passthrough) begin
    if (recent_reset) begin
      state    <= holo_pkg::FETCH_IDLE;
      tri_id_o <= '0;
    end else begin
      case (state)
        holo_pkg::FETCH_IDLE: begin
          // id moves together with the entry into issue
          if (step_edge && raster_ready_i) begin
            state    <= holo_pkg::FETCH_ISSUE;
            tri_id_o <= tri_id_next;
          end
        end
        // single valid cycle
        holo_pkg::FETCH_ISSUE: begin
          state <= holo_pkg::FETCH_IDLE;
        end
        default: begin
          state <= holo_pkg::FETCH_IDLE;
        end
      endcase
    end
  end

  assign tri_valid_o = (state == holo_pkg::FETCH_ISSUE);

  // clear leaves as the raw edge pulse
  assign clear_o = clear_edge;

endmodule

`default_nettype wire

/* rtl/probe_select.sv */
// probe codes above 5 show zero; a vertex or coordinate field of 3 keeps the last vertex value
`timescale 1ns/1ps
`default_nettype none

module probe_select (
  input  wire                            clk_100_passthrough,
  input  wire                            recent_reset,
  input  wire  [15:0]                    sw_i,
  input  wire  [holo_pkg::TRI_ID_W-1:0]  tri_id_i,
  input  wire                            tri_valid_i,
  input  wire  [holo_pkg::HCOUNT_W-1:0]  hcount_i,
  input  wire  [holo_pkg::VCOUNT_W-1:0]  vcount_i,
  input  wire  [holo_pkg::PIXEL_W-1:0]   last_pixel_i,
  output logic [holo_pkg::DISP_W-1:0]    disp_val_o
);

  // switch fields
  logic [1:0] vtx_sel;
  logic [1:0] crd_sel;
  logic [3:0] elem_idx;

  holo_pkg::probe_sel_e probe_sel;

  // selected coordinate, one cycle behind the switches
  logic [holo_pkg::COORD_W-1:0] vertex_q;

  assign vtx_sel = sw_i[3:2];
  assign crd_sel = sw_i[5:4];

  // flat table position
  assign elem_idx = 4'(vtx_sel) * 4'(holo_pkg::TABLE_DIM) + 4'(crd_sel);

  assign probe_sel = holo_pkg::probe_sel_e'(sw_i[15:10]);

  always_ff @(posedge clk_100_passthrough) begin
    if (recent_reset) begin
      vertex_q <= '0;
    end else if (vtx_sel < 2'(holo_pkg::TABLE_DIM) &&
                 crd_sel < 2'(holo_pkg::TABLE_DIM)) begin
      vertex_q <= holo_pkg::VERTEX_TABLE[elem_idx*holo_pkg::COORD_W +: holo_pkg::COORD_W];
    end
  end

  // display register, all values zero-extended
  always_ff @(posedge clk_100_passthrough) begin
    if (recent_reset) begin
      disp_val_o <= '0;
    end else begin
      case (probe_sel)
        holo_pkg::PROBE_TRI_ID:     disp_val_o <= holo_pkg::DISP_W'(tri_id_i);
        holo_pkg::PROBE_VERTEX:     disp_val_o <= holo_pkg::DISP_W'(vertex_q);
        holo_pkg::PROBE_TRI_VALID:  disp_val_o <= holo_pkg::DISP_W'(tri_valid_i);
        holo_pkg::PROBE_HCOUNT:     disp_val_o <= holo_pkg::DISP_W'(hcount_i);
        holo_pkg::PROBE_VCOUNT:     disp_val_o <= holo_pkg::DISP_W'(vcount_i);
        holo_pkg::PROBE_LAST_PIXEL: disp_val_o <= holo_pkg::DISP_W'(last_pixel_i);
        // unused codes
        default:                    disp_val_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/pixel_unpack.sv */
// ready is combinational from the counters; the source must not present data while ready is low
`timescale 1ns/1ps
`default_nettype none

module pixel_unpack (
  input  wire                            clk_100_passthrough,
  input  wire                            recent_reset,
  input  wire  [holo_pkg::HCOUNT_W-1:0]  hcount_i,
  input  wire  [holo_pkg::VCOUNT_W-1:0]  vcount_i,
  input  wire                            active_draw_i,
  input  wire                            fb_tvalid_i,
  input  wire  [holo_pkg::PIXEL_W-1:0]   fb_tdata_i,
  input  wire                            fb_tlast_i,
  output logic                           fb_tready_o,
  output logic [holo_pkg::CHAN_W-1:0]    red_o,
  output logic [holo_pkg::CHAN_W-1:0]    green_o,
  output logic [holo_pkg::CHAN_W-1:0]    blue_o,
  output logic [holo_pkg::PIXEL_W-1:0]   last_pixel_o
);

  logic                          accept;
  logic [holo_pkg::PIXEL_W-1:0]  pixel;

  // last pixel only at the final position of an active frame
  assign fb_tready_o = fb_tlast_i ?
    (active_draw_i &&
     hcount_i == holo_pkg::HCOUNT_W'(holo_pkg::HRES - 1) &&
     vcount_i == holo_pkg::VCOUNT_W'(holo_pkg::VRES - 1)) :
    (hcount_i < holo_pkg::HCOUNT_W'(holo_pkg::HRES) &&
     vcount_i < holo_pkg::VCOUNT_W'(holo_pkg::VRES));

  assign accept = fb_tvalid_i && fb_tready_o;
  // gray when nothing is taken
  assign pixel  = accept ? fb_tdata_i : holo_pkg::GRAY_PIXEL;

  // 565 to 888, low bits zero
  always_ff @(posedge clk_100_passthrough) begin
    if (recent_reset) begin
      red_o   <= {holo_pkg::GRAY_PIXEL[15:11], 3'b0};
      green_o <= {holo_pkg::GRAY_PIXEL[10:5], 2'b0};
      blue_o  <= {holo_pkg::GRAY_PIXEL[4:0], 3'b0};
    end else begin
      red_o   <= {pixel[15:11], 3'b0};
      green_o <= {pixel[10:5], 2'b0};
      blue_o  <= {pixel[4:0], 3'b0};
    end
  end

  // kept for the display probe
  always_ff @(posedge clk_100_passthrough) begin
    if (recent_reset) begin
      last_pixel_o <= '0;
    end else if (accept) begin
      last_pixel_o <= fb_tdata_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/holo_debug_top.sv */
// single clock domain; pixel stream source must honor fb_tready_o as there is no back-pressure
`timescale 1ns/1ps
`default_nettype none

module holo_debug_top (
  input  wire                              clk_100_passthrough,
  input  wire                              recent_reset,
  // buttons and switches
  input  wire  [3:0]                       btn_i,
  input  wire  [15:0]                      sw_i,
  input  wire                              raster_ready_i,
  // video timing
  input  wire  [holo_pkg::HCOUNT_W-1:0]    hcount_i,
  input  wire  [holo_pkg::VCOUNT_W-1:0]    vcount_i,
  input  wire                              active_draw_i,
  // framebuffer stream
  input  wire                              fb_tvalid_i,
  input  wire  [holo_pkg::PIXEL_W-1:0]     fb_tdata_i,
  input  wire                              fb_tlast_i,
  // triangle fetch
  output logic                             tri_valid_o,
  output logic [holo_pkg::TRI_ID_W-1:0]    tri_id_o,
  output logic                             clear_o,
  // pixel readout
  output logic                             fb_tready_o,
  output logic [holo_pkg::CHAN_W-1:0]      red_o,
  output logic [holo_pkg::CHAN_W-1:0]      green_o,
  output logic [holo_pkg::CHAN_W-1:0]      blue_o,
  // display, active low
  output logic [holo_pkg::NUM_DIGITS-1:0]  an_o,
  output logic [6:0]                       cat_o
);

  // last accepted pixel, for the probe
  logic [holo_pkg::PIXEL_W-1:0] last_pixel;
  // value on the display
  logic [holo_pkg::DISP_W-1:0]  disp_val;

  // buttons and triangle stepping
  debug_ctrl debug_ctrl_i (
    .clk_100_passthrough (clk_100_passthrough),
    .recent_reset        (recent_reset),
    .btn_i               (btn_i),
    .raster_ready_i      (raster_ready_i),
    .tri_valid_o         (tri_valid_o),
    .tri_id_o            (tri_id_o),
    .clear_o             (clear_o)
  );

  // framebuffer readout
  pixel_unpack pixel_unpack_i (
    .clk_100_passthrough (clk_100_passthrough),
    .recent_reset        (recent_reset),
    .hcount_i            (hcount_i),
    .vcount_i            (vcount_i),
    .active_draw_i       (active_draw_i),
    .fb_tvalid_i         (fb_tvalid_i),
    .fb_tdata_i          (fb_tdata_i),
    .fb_tlast_i          (fb_tlast_i),
    .fb_tready_o         (fb_tready_o),
    .red_o               (red_o),
    .green_o             (green_o),
    .blue_o              (blue_o),
    .last_pixel_o        (last_pixel)
  );

  // probe mux, fed by the two blocks above
  probe_select probe_select_i (
    .clk_100_passthrough (clk_100_passthrough),
    .recent_reset        (recent_reset),
    .sw_i                (sw_i),
    .tri_id_i            (tri_id_o),
    .tri_valid_i         (tri_valid_o),
    .hcount_i            (hcount_i),
    .vcount_i            (vcount_i),
    .last_pixel_i        (last_pixel),
    .disp_val_o          (disp_val)
  );

  // eight digit scanner
  seven_seg_scan seven_seg_scan_i (
    .clk_100_passthrough (clk_100_passthrough),
    .recent_reset        (recent_reset),
    .val_i               (disp_val),
    .an_o                (an_o),
    .cat_o               (cat_o)
  );

endmodule

`default_nettype wire

/* testbench/holo_debug_assert.sv */
// protocol properties on holo_debug_top, sampled on the rising edge and off during reset
`timescale 1ns/1ps
`default_nettype none

module holo_debug_assert (
  input wire                              clk_100_passthrough,
  input wire                              recent_reset,
  input wire                              tri_valid_o,
  input wire [holo_pkg::NUM_DIGITS-1:0]   an_o,
  input wire                              fb_tready_o,
  input wire                              fb_tlast_i,
  input wire                              active_draw_i,
  input wire [holo_pkg::HCOUNT_W-1:0]     hcount_i,
  input wire [holo_pkg::VCOUNT_W-1:0]     vcount_i
);

  // failed properties so far
  int fail_count = 0;

  // one valid cycle per step
  valid_single: assert property (@(posedge clk_100_passthrough) disable iff (recent_reset)
    tri_valid_o |=> !tri_valid_o)
    else begin
      fail_count++;
      $error("tri_valid_o high in two consecutive cycles");
    end

  // exactly one anode driven
  one_anode: assert property (@(posedge clk_100_passthrough) disable iff (recent_reset)
    $onehot(~an_o))
    else begin
      fail_count++;
      $error("an_o does not have exactly one low bit");
    end

  // last pixel only at the final active position
  ready_rule: assert property (@(posedge clk_100_passthrough) disable iff (recent_reset)
    fb_tready_o == (fb_tlast_i ?
      (active_draw_i && hcount_i == holo_pkg::HCOUNT_W'(holo_pkg::HRES - 1) &&
       vcount_i == holo_pkg::VCOUNT_W'(holo_pkg::VRES - 1)) :
      (hcount_i < holo_pkg::HCOUNT_W'(holo_pkg::HRES) &&
       vcount_i < holo_pkg::VCOUNT_W'(holo_pkg::VRES))))
    else begin
      fail_count++;
      $error("fb_tready_o breaks the ready rule");
    end

endmodule

bind holo_debug_top holo_debug_assert holo_debug_assert_i (
  .clk_100_passthrough (clk_100_passthrough),
  .recent_reset        (recent_reset),
  .tri_valid_o         (tri_valid_o),
  .an_o                (an_o),
  .fb_tready_o         (fb_tready_o),
  .fb_tlast_i          (fb_tlast_i),
  .active_draw_i       (active_draw_i),
  .hcount_i            (hcount_i),
  .vcount_i            (vcount_i)
);

`default_nettype wire

/* testbench/tb_holo_debug.sv */
// directed tests on holo_debug_top; inputs change 2 ns after the rising edge, run ends at 20000 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_holo_debug;

  // scan waits dominate the run, limit leaves a wide margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] SEED = 32'h0197b1c9;
  // standard hex segments, bit 0 = a, active high
  localparam logic [6:0] SEG_TABLE [16] = '{
    7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
    7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
  };

  logic clk_100_passthrough;
  logic recent_reset;
  logic [3:0] btn_i;
  logic [15:0] sw_i;
  logic raster_ready_i;
  logic [holo_pkg::HCOUNT_W-1:0] hcount_i;
  logic [holo_pkg::VCOUNT_W-1:0] vcount_i;
  logic active_draw_i;
  logic fb_tvalid_i;
  logic [holo_pkg::PIXEL_W-1:0] fb_tdata_i;
  logic fb_tlast_i;
  logic tri_valid_o;
  logic [holo_pkg::TRI_ID_W-1:0] tri_id_o;
  logic clear_o;
  logic fb_tready_o;
  logic [holo_pkg::CHAN_W-1:0] red_o;
  logic [holo_pkg::CHAN_W-1:0] green_o;
  logic [holo_pkg::CHAN_W-1:0] blue_o;
  logic [holo_pkg::NUM_DIGITS-1:0] an_o;
  logic [6:0] cat_o;

  // bookkeeping
  string cur_test;
  int errors = 0;
  int err_start = 0;
  int tests = 0;
  int cycles = 0;
  // expected triangle id, kept by the testbench
  logic [holo_pkg::TRI_ID_W-1:0] model_id = '0;
  // last pixel taken by the DUT
  logic [holo_pkg::PIXEL_W-1:0] sent_pixel = '0;

  holo_debug_top holo_debug_top_i (.*);

  initial begin
    clk_100_passthrough = 1'b0;
    forever #10 clk_100_passthrough = ~clk_100_passthrough;
  end

  // next drive point, 2 ns past the edge
  task automatic tick();
    @(posedge clk_100_passthrough);
    #2;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    err_start = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("%s finished, %0d errors", cur_test, errors - err_start);
  endtask

  task automatic mismatch(input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("error %s expected %0h actual %0h", cur_test, exp, act);
  endtask

  task automatic fault(input string msg);
    errors++;
    $display("%s failed: %s", cur_test, msg);
  endtask

  // ready rule as given for the framebuffer stream
  function automatic logic ready_rule(input logic [holo_pkg::HCOUNT_W-1:0] h,
                                      input logic [holo_pkg::VCOUNT_W-1:0] v,
                                      input logic last, input logic act);
    if (last) begin
      return act && h == holo_pkg::HCOUNT_W'(holo_pkg::HRES - 1) &&
             v == holo_pkg::VCOUNT_W'(holo_pkg::VRES - 1);
    end
    return h < holo_pkg::HCOUNT_W'(holo_pkg::HRES) && v < holo_pkg::VCOUNT_W'(holo_pkg::VRES);
  endfunction

  // 565 to 888 with zero low bits, packed r g b
  function automatic logic [23:0] expand(input logic [15:0] p);
    return {p[15:11], 3'b0, p[10:5], 2'b0, p[4:0], 3'b0};
  endfunction

  // hold one button for 6 cycles, release for 3, count pulses on its output
  task automatic press_button(input int bit_idx, output int pulses, output int first_at);
    logic seen;
    pulses   = 0;
    first_at = -1;
    btn_i[bit_idx] = 1'b1;
    for (int i = 1; i <= 9; i++) begin
      tick();
      if (i == 6) btn_i[bit_idx] = 1'b0;
      seen = (bit_idx == 1) ? tri_valid_o : clear_o;
      if (seen) begin
        pulses++;
        if (first_at < 0) first_at = i;
      end
    end
  endtask

  task automatic reset_state();
    begin_test("reset_state");
    for (int i = 0; i < 4; i++) begin
      if (tri_valid_o !== 1'b0) mismatch(32'd0, 32'(tri_valid_o));
      if (clear_o !== 1'b0) mismatch(32'd0, 32'(clear_o));
      if (tri_id_o !== '0) mismatch(32'd0, 32'(tri_id_o));
      if ({red_o, green_o, blue_o} !== expand(holo_pkg::GRAY_PIXEL)) begin
        mismatch(32'(expand(holo_pkg::GRAY_PIXEL)), 32'({red_o, green_o, blue_o}));
      end
      tick();
    end
    end_test();
  endtask

  task automatic step_fetch();
    int pulses;
    int first_at;
    begin_test("step_fetch");
    raster_ready_i = 1'b1;
    // 13 steps cross the wrap at NUM_TRI
    for (int n = 0; n < 13; n++) begin
      if (model_id == holo_pkg::TRI_ID_W'(holo_pkg::NUM_TRI - 1)) model_id = '0;
      else model_id = model_id + holo_pkg::TRI_ID_W'(1);
      press_button(1, pulses, first_at);
      if (pulses != 1) mismatch(32'd1, 32'(pulses));
      // edge after 2 cycles, valid one cycle on
      if (first_at != 3) mismatch(32'd3, 32'(first_at));
      if (tri_id_o !== model_id) mismatch(32'(model_id), 32'(tri_id_o));
    end
    if (tri_id_o !== holo_pkg::TRI_ID_W'(1)) mismatch(32'd1, 32'(tri_id_o));
    // rasterizer busy, step is lost
    raster_ready_i = 1'b0;
    press_button(1, pulses, first_at);
    if (pulses != 0) mismatch(32'd0, 32'(pulses));
    if (tri_id_o !== model_id) mismatch(32'(model_id), 32'(tri_id_o));
    raster_ready_i = 1'b1;
    end_test();
  endtask

  task automatic clear_pulse();
    int pulses;
    int first_at;
    begin_test("clear_pulse");
    press_button(2, pulses, first_at);
    if (pulses != 1) mismatch(32'd1, 32'(pulses));
    if (first_at != 2) mismatch(32'd2, 32'(first_at));
    end_test();
  endtask

  task automatic pixel_readout();
    logic exp_rdy;
    logic [15:0] pix;
    int accepted;
    begin_test("pixel_readout");
    accepted = 0;
    for (int n = 0; n < 300; n++) begin
      // a quarter of the samples sit on the last frame position
      if ($urandom % 4 == 0) begin
        hcount_i = holo_pkg::HCOUNT_W'(holo_pkg::HRES - 1);
        vcount_i = holo_pkg::VCOUNT_W'(holo_pkg::VRES - 1);
      end else begin
        hcount_i = holo_pkg::HCOUNT_W'($urandom % (holo_pkg::HRES + 64));
        vcount_i = holo_pkg::VCOUNT_W'($urandom % (holo_pkg::VRES + 40));
      end
      fb_tlast_i    = 1'($urandom % 2);
      active_draw_i = 1'($urandom % 2);
      fb_tvalid_i   = ($urandom % 4) != 0;
      fb_tdata_i    = 16'($urandom);
      #1;
      exp_rdy = ready_rule(hcount_i, vcount_i, fb_tlast_i, active_draw_i);
      if (fb_tready_o !== exp_rdy) mismatch(32'(exp_rdy), 32'(fb_tready_o));
      pix = (fb_tvalid_i && exp_rdy) ? fb_tdata_i : holo_pkg::GRAY_PIXEL;
      if (fb_tvalid_i && exp_rdy) begin
        sent_pixel = fb_tdata_i;
        accepted++;
      end
      tick();
      if ({red_o, green_o, blue_o} !== expand(pix)) begin
        mismatch(32'(expand(pix)), 32'({red_o, green_o, blue_o}));
      end
    end
    fb_tvalid_i = 1'b0;
    if (accepted == 0) fault("no pixel was accepted during the run");
    end_test();
  endtask

  // walk the scan and compare every digit with the expected value
  task automatic check_display(input logic [31:0] exp_val);
    logic [6:0] exp_seg;
    // display register and vertex register settle
    repeat (4) tick();
    for (int d = 0; d < holo_pkg::NUM_DIGITS; d++) begin
      while (an_o !== ~(8'(1) << d)) tick();
      exp_seg = ~SEG_TABLE[exp_val[d*4 +: 4]];
      if (cat_o !== exp_seg) begin
        mismatch(32'(exp_seg), 32'(cat_o));
      end
    end
  endtask

  task automatic display_readout();
    begin_test("display_readout");
    sw_i = {6'(holo_pkg::PROBE_TRI_ID), 10'b0};
    check_display(32'(model_id));
    // vertex 2, coordinate 1
    sw_i = {6'(holo_pkg::PROBE_VERTEX), 4'b0, 2'd1, 2'd2, 2'b0};
    check_display(32'(holo_pkg::VERTEX_TABLE[(2 * 3 + 1) * holo_pkg::COORD_W +:
                                              holo_pkg::COORD_W]));
    sw_i = {6'(holo_pkg::PROBE_LAST_PIXEL), 10'b0};
    check_display(32'(sent_pixel));
    end_test();
  endtask

  // run limit
  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_100_passthrough);
      cycles++;
    end
    $display("run stopped, no result after %0d cycles", cycles);
    $display("Checks failed");
    $finish;
  end

  initial begin
    recent_reset   = 1'b1;
    btn_i          = '0;
    sw_i           = '0;
    raster_ready_i = 1'b0;
    hcount_i       = '0;
    vcount_i       = '0;
    active_draw_i  = 1'b0;
    fb_tvalid_i    = 1'b0;
    fb_tdata_i     = '0;
    fb_tlast_i     = 1'b0;
    void'($urandom(SEED));
    repeat (2) @(posedge clk_100_passthrough);
    #2;
    recent_reset = 1'b0;
    reset_state();
    step_fetch();
    clear_pulse();
    pixel_readout();
    display_readout();
    // failed properties of the bound checker
    if (holo_debug_top_i.holo_debug_assert_i.fail_count != 0) begin
      errors += holo_debug_top_i.holo_debug_assert_i.fail_count;
      $display("%0d assertion failures during the run",
               holo_debug_top_i.holo_debug_assert_i.fail_count);
    end
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
common/holo_pkg.sv
seven_seg/seven_seg_scan.sv
rtl/debug_ctrl.sv
rtl/probe_select.sv
rtl/pixel_unpack.sv
rtl/holo_debug_top.sv
testbench/holo_debug_assert.sv
testbench/tb_holo_debug.sv

/* Makefile */
# Verilator build and run for the holo debug testbench

VERILATOR ?= verilator
TOP       ?= tb_holo_debug
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) && echo "result: PASS" || (echo "result: FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
